//--- maze_pkg.sv
package maze_pkg;

    // Canvas geometry in pixels
    localparam int CANVAS_W     = 160;
    localparam int CANVAS_H     = 120;
    localparam int CANVAS_WORDS = CANVAS_W * CANVAS_H;  // 19200 words
    localparam int ADDR_W       = 15;
    localparam int COLOR_W      = 12;                   // 4 bits per channel

    // Maze geometry in tiles
    localparam int MAZE_COLS = 29;
    localparam int MAZE_ROWS = 13;
    localparam int TILE_PX   = 5;   // Tile edge

    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [ADDR_W-1:0]  canvas_addr_t;
    typedef logic [4:0]         tile_x_t;   // 0..28
    typedef logic [3:0]         tile_y_t;   // 0..12

    localparam color_t WALL_COLOR   = 12'h00F;
    localparam color_t FLOOR_COLOR  = 12'h000;
    localparam color_t PLAYER_COLOR = 12'hFA8;

    localparam int PLAYER_START_X = 1;
    localparam int PLAYER_START_Y = 1;
    localparam int NUM_GHOSTS     = 3;

    typedef struct packed {
        tile_x_t x;   // Upper 5 bits
        tile_y_t y;   // Lower 4 bits
    } tile_pos_t;

    // Same coding as the keypad direction word
    typedef enum logic [2:0] {
        DIR_NONE  = 3'd0,
        DIR_UP    = 3'd1,
        DIR_LEFT  = 3'd2,
        DIR_DOWN  = 3'd3,
        DIR_RIGHT = 3'd4
    } dir_t;

    // Border ring plus a pillar on every even/even tile
    function automatic logic is_wall(tile_pos_t pos);
        logic border;
        logic pillar;
        border = (pos.x == '0) || (pos.x == tile_x_t'(MAZE_COLS - 1)) ||
                 (pos.y == '0) || (pos.y == tile_y_t'(MAZE_ROWS - 1));
        pillar = !pos.x[0] && !pos.y[0];
        return border || pillar;
    endfunction

endpackage

//--- canvas_write_if.sv
`timescale 1ns/1ps

// One stage handshake plus its canvas write port
interface canvas_write_if import maze_pkg::*; ();

    logic         start;      // Pulse from the sequencer
    logic         finished;   // Pulse from the stage after its last write
    logic         wren;       // High only while the stage is busy
    canvas_addr_t addr;       // Scanout reuses this as read address
    color_t       data;

    modport stage (
        input  start,
        output finished,
        output wren,
        output addr,
        output data
    );

    modport sequencer (
        output start,
        input  finished,
        input  wren,
        input  addr,
        input  data
    );

endinterface

//--- player_motion.sv
`timescale 1ns/1ps

module player_motion import maze_pkg::*; (
    input  logic                          clock,
    input  logic                          resetn,
    canvas_write_if.stage                 ctrl,
    input  dir_t                          direction,
    input  tile_pos_t [NUM_GHOSTS-1:0]    ghost_pos,
    output tile_pos_t                     player_pos,
    output logic                          collided
);

    tile_pos_t target;     // Neighbor tile in the requested direction
    tile_pos_t next_pos;   // Target, or stay put when it is a wall
    logic      hit;        // Some ghost sits on next_pos

    always_comb begin
        target = player_pos;
        case (direction)
            DIR_UP:    target.y = player_pos.y - 4'd1;
            DIR_LEFT:  target.x = player_pos.x - 5'd1;
            DIR_DOWN:  target.y = player_pos.y + 4'd1;
            DIR_RIGHT: target.x = player_pos.x + 5'd1;
            default:   target = player_pos;   // DIR_NONE holds
        endcase
    end

    // Player never sits on the border, so no wrap is possible
    assign next_pos = is_wall(target) ? player_pos : target;

    always_comb begin
        hit = 1'b0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            if (ghost_pos[g] == next_pos) begin
                hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            player_pos.x  <= tile_x_t'(PLAYER_START_X);
            player_pos.y  <= tile_y_t'(PLAYER_START_Y);
            collided      <= 1'b0;
            ctrl.finished <= 1'b0;
        end else begin
            ctrl.finished <= ctrl.start;   // Single-cycle stage
            if (ctrl.start) begin
                player_pos <= next_pos;
                collided   <= hit;         // Checked against the new tile
            end
        end
    end

    // No canvas traffic from this stage
    assign ctrl.wren = 1'b0;
    assign ctrl.addr = '0;
    assign ctrl.data = FLOOR_COLOR;

endmodule

//--- maze_painter.sv
`timescale 1ns/1ps

module maze_painter import maze_pkg::*; (
    input  logic          clock,
    input  logic          resetn,
    canvas_write_if.stage ctrl
);

    logic       busy;
    logic [2:0] px;        // Pixel column inside tile
    logic [2:0] py;        // Pixel row inside tile
    tile_x_t    tx;        // Tile column
    tile_y_t    ty;        // Tile row
    logic       px_end;
    logic       py_end;
    logic       tx_end;
    logic       ty_end;
    tile_pos_t  tile;
    logic [7:0] pix_x;     // Canvas column, max 144
    logic [6:0] pix_y;     // Canvas row, max 64

    assign px_end = (px == 3'(TILE_PX - 1));
    assign py_end = (py == 3'(TILE_PX - 1));
    assign tx_end = (tx == tile_x_t'(MAZE_COLS - 1));
    assign ty_end = (ty == tile_y_t'(MAZE_ROWS - 1));

    assign tile  = '{x: tx, y: ty};
    assign pix_x = 8'(tx * TILE_PX + px);   // Tile origin plus offset
    assign pix_y = 7'(ty * TILE_PX + py);

    // One write per busy cycle
    assign ctrl.wren = busy;
    assign ctrl.addr = canvas_addr_t'(pix_y * CANVAS_W + pix_x);
    assign ctrl.data = is_wall(tile) ? WALL_COLOR : FLOOR_COLOR;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy          <= 1'b0;
            ctrl.finished <= 1'b0;
            px            <= '0;
            py            <= '0;
            tx            <= '0;
            ty            <= '0;
        end else begin
            ctrl.finished <= 1'b0;
            if (ctrl.start) begin
                busy <= 1'b1;        // Counters already rest at zero
            end else if (busy) begin
                if (!px_end) begin
                    px <= px + 3'd1;
                end else begin
                    px <= '0;
                    if (!py_end) begin
                        py <= py + 3'd1;
                    end else begin
                        py <= '0;
                        if (!tx_end) begin
                            tx <= tx + 5'd1;
                        end else begin
                            tx <= '0;
                            if (!ty_end) begin
                                ty <= ty + 4'd1;
                            end else begin
                                // Last of 9425 pixels
                                ty            <= '0;
                                busy          <= 1'b0;
                                ctrl.finished <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

//--- player_painter.sv
`timescale 1ns/1ps

module player_painter import maze_pkg::*; (
    input  logic          clock,
    input  logic          resetn,
    canvas_write_if.stage ctrl,
    input  tile_pos_t     player_pos
);

    logic       busy;
    logic [7:0] org_x;    // Pixel origin of the player tile
    logic [6:0] org_y;
    logic [2:0] px;       // Offset inside the square
    logic [2:0] py;
    logic       px_end;
    logic       py_end;
    logic [7:0] pix_x;
    logic [6:0] pix_y;

    assign px_end = (px == 3'(TILE_PX - 1));
    assign py_end = (py == 3'(TILE_PX - 1));
    assign pix_x  = org_x + 8'(px);
    assign pix_y  = org_y + 7'(py);

    // Solid square, raster order
    assign ctrl.wren = busy;
    assign ctrl.addr = canvas_addr_t'(pix_y * CANVAS_W + pix_x);
    assign ctrl.data = PLAYER_COLOR;

    // Origin latched at start
    always_ff @(posedge clock) begin
        if (ctrl.start) begin
            org_x <= 8'(player_pos.x * TILE_PX);
            org_y <= 7'(player_pos.y * TILE_PX);
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy          <= 1'b0;
            ctrl.finished <= 1'b0;
            px            <= '0;
            py            <= '0;
        end else begin
            ctrl.finished <= 1'b0;
            if (ctrl.start) begin
                busy <= 1'b1;
            end else if (busy) begin
                px <= px_end ? 3'd0 : px + 3'd1;
                if (px_end) begin
                    py <= py_end ? 3'd0 : py + 3'd1;
                    if (py_end) begin
                        busy          <= 1'b0;   // 25th write done
                        ctrl.finished <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import maze_pkg::*; (
    input  logic         clock,
    input  logic         wren,
    input  canvas_addr_t waddr,
    input  color_t       wdata,
    input  canvas_addr_t raddr,
    output color_t       rdata
);

    color_t mem [CANVAS_WORDS];   // One word per canvas pixel

    // Power-up image is a blank canvas
    initial begin
        for (int i = 0; i < CANVAS_WORDS; i++) begin
            mem[i] = FLOOR_COLOR;
        end
    end

    // Write port
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, data one cycle after address
    always_ff @(posedge clock) begin
        rdata <= mem[raddr];
    end

endmodule

//--- canvas_scanout.sv
`timescale 1ns/1ps

module canvas_scanout import maze_pkg::*; (
    input  logic          clock,
    input  logic          resetn,
    canvas_write_if.stage ctrl,
    input  color_t        rdata,
    output logic          vga_valid,
    output logic [7:0]    vga_x,
    output logic [6:0]    vga_y,
    output color_t        vga_color
);

    logic       busy;
    logic [7:0] col;      // Address-side column
    logic [6:0] row;      // Address-side row
    logic       col_end;
    logic       row_end;

    assign col_end = (col == 8'(CANVAS_W - 1));
    assign row_end = (row == 7'(CANVAS_H - 1));

    // addr lines serve as the read address
    assign ctrl.addr = canvas_addr_t'(row * CANVAS_W + col);
    assign ctrl.wren = 1'b0;              // Read-only stage
    assign ctrl.data = FLOOR_COLOR;

    assign vga_color = rdata;             // Already one cycle behind addr

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy          <= 1'b0;
            col           <= '0;
            row           <= '0;
            vga_valid     <= 1'b0;
            ctrl.finished <= 1'b0;
        end else begin
            vga_valid <= busy;   // Align with read latency
            // Finish right after the bottom-right pixel
            ctrl.finished <= vga_valid && (vga_x == 8'(CANVAS_W - 1)) &&
                             (vga_y == 7'(CANVAS_H - 1));
            if (ctrl.start) begin
                busy <= 1'b1;
            end else if (busy) begin
                col <= col_end ? 8'd0 : col + 8'd1;
                if (col_end) begin
                    row <= row_end ? 7'd0 : row + 7'd1;
                    busy <= !row_end;   // Stop after address 19199
                end
            end
        end
    end

    // Pixel position trails the address by one cycle
    always_ff @(posedge clock) begin
        vga_x <= col;
        vga_y <= row;
    end

endmodule

//--- frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer import maze_pkg::*; (
    input  logic               clock,
    input  logic               resetn,
    input  logic               frame_start,
    output logic               frame_done,
    canvas_write_if.sequencer  motion,
    canvas_write_if.sequencer  maze,
    canvas_write_if.sequencer  player,
    canvas_write_if.sequencer  scan,
    output logic               fb_wren,
    output canvas_addr_t       fb_waddr,
    output color_t             fb_wdata,
    output canvas_addr_t       fb_raddr
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MOTION,
        S_MAZE,
        S_PLAYER,
        S_SCAN
    } state_t;

    state_t state;

    // Each start is pulsed on entry to its state
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state        <= S_IDLE;
            motion.start <= 1'b0;
            maze.start   <= 1'b0;
            player.start <= 1'b0;
            scan.start   <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            motion.start <= 1'b0;
            maze.start   <= 1'b0;
            player.start <= 1'b0;
            scan.start   <= 1'b0;
            frame_done   <= 1'b0;
            case (state)
                S_IDLE: if (frame_start) begin   // Only sampled here
                    state        <= S_MOTION;
                    motion.start <= 1'b1;
                end
                S_MOTION: if (motion.finished) begin
                    state      <= S_MAZE;
                    maze.start <= 1'b1;
                end
                S_MAZE: if (maze.finished) begin
                    state        <= S_PLAYER;
                    player.start <= 1'b1;
                end
                S_PLAYER: if (player.finished) begin
                    state      <= S_SCAN;
                    scan.start <= 1'b1;
                end
                S_SCAN: if (scan.finished) begin
                    state      <= S_IDLE;
                    frame_done <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Write port follows the current stage
    always_comb begin
        case (state)
            S_MOTION: {fb_wren, fb_waddr, fb_wdata} = {motion.wren, motion.addr, motion.data};
            S_MAZE:   {fb_wren, fb_waddr, fb_wdata} = {maze.wren, maze.addr, maze.data};
            S_PLAYER: {fb_wren, fb_waddr, fb_wdata} = {player.wren, player.addr, player.data};
            S_SCAN:   {fb_wren, fb_waddr, fb_wdata} = {scan.wren, scan.addr, scan.data};
            default:  {fb_wren, fb_waddr, fb_wdata} = '0;
        endcase
    end

    assign fb_raddr = scan.addr;   // Only scanout reads

endmodule

//--- maze_frame.sv
`timescale 1ns/1ps

module maze_frame import maze_pkg::*; (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          frame_start,
    input  dir_t                          direction,
    input  tile_pos_t [NUM_GHOSTS-1:0]    ghost_pos,
    output logic                          frame_done,
    output logic                          collided,
    output logic                          vga_valid,
    output logic [7:0]                    vga_x,
    output logic [6:0]                    vga_y,
    output color_t                        vga_color
);

    // Stage handshakes
    canvas_write_if motion_if ();
    canvas_write_if maze_if ();
    canvas_write_if player_if ();
    canvas_write_if scan_if ();

    logic         fb_wren;
    canvas_addr_t fb_waddr;
    color_t       fb_wdata;
    canvas_addr_t fb_raddr;
    color_t       fb_rdata;
    tile_pos_t    player_pos;   // Motion result for the painter

    frame_sequencer u_frame_sequencer (
        .clock       (clock),
        .resetn      (resetn),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .motion      (motion_if.sequencer),
        .maze        (maze_if.sequencer),
        .player      (player_if.sequencer),
        .scan        (scan_if.sequencer),
        .fb_wren     (fb_wren),
        .fb_waddr    (fb_waddr),
        .fb_wdata    (fb_wdata),
        .fb_raddr    (fb_raddr)
    );

    player_motion u_player_motion (
        .clock      (clock),
        .resetn     (resetn),
        .ctrl       (motion_if.stage),
        .direction  (direction),
        .ghost_pos  (ghost_pos),
        .player_pos (player_pos),
        .collided   (collided)
    );

    maze_painter u_maze_painter (
        .clock  (clock),
        .resetn (resetn),
        .ctrl   (maze_if.stage)
    );

    player_painter u_player_painter (
        .clock      (clock),
        .resetn     (resetn),
        .ctrl       (player_if.stage),
        .player_pos (player_pos)
    );

    frame_buffer u_frame_buffer (
        .clock (clock),
        .wren  (fb_wren),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .raddr (fb_raddr),
        .rdata (fb_rdata)
    );

    canvas_scanout u_canvas_scanout (
        .clock     (clock),
        .resetn    (resetn),
        .ctrl      (scan_if.stage),
        .rdata     (fb_rdata),
        .vga_valid (vga_valid),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color)
    );

endmodule

//--- tb_maze_frame.sv
`timescale 1ns/1ps

module tb_maze_frame import maze_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 30000;   // Upper bound on one frame
    localparam int NUM_FRAMES   = 18;      // 1 + 3 + 2 + 1 + 10, plus one quiet frame
    localparam int WATCHDOG_NS  = (NUM_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;

    logic                       clock;
    logic                       resetn;
    logic                       frame_start;
    dir_t                       direction;
    tile_pos_t [NUM_GHOSTS-1:0] ghost_pos;
    logic                       frame_done;
    logic                       collided;
    logic                       vga_valid;
    logic [7:0]                 vga_x;
    logic [6:0]                 vga_y;
    color_t                     vga_color;

    color_t      pixels [CANVAS_WORDS];   // One scanned frame
    int          pix_count;
    tile_pos_t   ref_pos;                 // Model player tile
    logic        ref_coll;
    logic [31:0] rng;
    int          errors;
    int          checks;

    maze_frame u_maze_frame (
        .clock       (clock),
        .resetn      (resetn),
        .frame_start (frame_start),
        .direction   (direction),
        .ghost_pos   (ghost_pos),
        .frame_done  (frame_done),
        .collided    (collided),
        .vga_valid   (vga_valid),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_color   (vga_color)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    // frame_done is a single-cycle pulse
    done_pulse: assert property (@(posedge clock) disable iff (!resetn) frame_done |=> !frame_done)
        else begin
            $display("frame_done stayed high for more than one cycle");
            errors++;
        end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Neighbor tile, or stay when it is a wall
    function automatic tile_pos_t next_tile(tile_pos_t pos, dir_t dir);
        tile_pos_t t;
        t = pos;
        if (dir == DIR_UP) begin
            t.y = pos.y - 4'd1;
        end else if (dir == DIR_DOWN) begin
            t.y = pos.y + 4'd1;
        end else if (dir == DIR_LEFT) begin
            t.x = pos.x - 5'd1;
        end else if (dir == DIR_RIGHT) begin
            t.x = pos.x + 5'd1;
        end
        return is_wall(t) ? pos : t;
    endfunction

    function automatic color_t expected_pixel(int x, int y, tile_pos_t p);
        tile_pos_t t;
        if (x >= MAZE_COLS * TILE_PX || y >= MAZE_ROWS * TILE_PX) begin
            return 12'h000;   // Outside the maze, never painted
        end
        t.x = tile_x_t'(x / TILE_PX);
        t.y = tile_y_t'(y / TILE_PX);
        if (t == p) begin
            return PLAYER_COLOR;
        end
        return is_wall(t) ? WALL_COLOR : FLOOR_COLOR;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - mark);
        end
    endtask

    // One frame, optional second start pulse in the middle
    task automatic run_frame(input dir_t dir, input tile_pos_t [NUM_GHOSTS-1:0] ghosts,
                             input bit extra_start);
        int cycles;
        bit done_seen;
        @(posedge clock);
        frame_start <= 1'b1;
        direction   <= dir;
        ghost_pos   <= ghosts;
        pix_count = 0;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < FRAME_CYCLES) begin
            @(posedge clock);
            frame_start <= extra_start && (cycles == 300);   // Lands in the maze stage
            @(negedge clock);                                // Outputs settled
            cycles++;
            if (vga_valid) begin
                check_hex("vga_x", 32'(vga_x), 32'(pix_count % CANVAS_W));
                check_hex("vga_y", 32'(vga_y), 32'(pix_count / CANVAS_W));
                if (pix_count < CANVAS_WORDS) begin
                    pixels[pix_count] = vga_color;
                end
                pix_count++;
            end
            done_seen = frame_done;
        end
        checks++;
        assert (done_seen) else begin
            $display("frame_done never arrived within %0d cycles", FRAME_CYCLES);
            errors++;
        end
        check_hex("pixel count", 32'(pix_count), 32'(CANVAS_WORDS));
        // Nothing more may follow the frame
        repeat (extra_start ? FRAME_CYCLES : 50) begin   // Long enough for a queued frame
            @(negedge clock);
            checks++;
            assert (!frame_done && !vga_valid) else begin
                $display("frame_done or vga_valid seen after the frame ended");
                errors++;
            end
        end
    endtask

    task automatic compare_canvas();
        color_t exp;
        for (int i = 0; i < CANVAS_WORDS; i++) begin
            exp = expected_pixel(i % CANVAS_W, i / CANVAS_W, ref_pos);
            checks++;
            assert (pixels[i] === exp) else begin
                $display("[FAIL] vga_color at x=%0d y=%0d: got %h expected %h",
                         i % CANVAS_W, i / CANVAS_W, pixels[i], exp);
                errors++;
            end
        end
    endtask

    // Model step, DUT frame, then compare everything
    task automatic frame_and_check(input dir_t dir, input tile_pos_t [NUM_GHOSTS-1:0] ghosts,
                                   input bit extra_start);
        ref_pos  = next_tile(ref_pos, dir);
        ref_coll = 1'b0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            if (ghosts[g] == ref_pos) begin
                ref_coll = 1'b1;
            end
        end
        run_frame(dir, ghosts, extra_start);
        check_hex("player_pos", 32'(u_maze_frame.player_pos), 32'(ref_pos));
        check_hex("collided", 32'(collided), 32'(ref_coll));
        compare_canvas();
    endtask

    initial begin
        tile_pos_t [NUM_GHOSTS-1:0] ghosts;
        dir_t                       dir;
        int                         mark;
        errors      = 0;
        checks      = 0;
        rng         = 32'd78712;
        ghosts[0]   = '{x: 5'd27, y: 4'd11};   // Far corner floor tiles
        ghosts[1]   = '{x: 5'd25, y: 4'd11};
        ghosts[2]   = '{x: 5'd23, y: 4'd11};
        resetn      = 1'b0;
        frame_start = 1'b0;
        direction   = DIR_NONE;
        ghost_pos   = ghosts;
        ref_pos     = '{x: tile_x_t'(PLAYER_START_X), y: tile_y_t'(PLAYER_START_Y)};
        repeat (5) @(posedge clock);
        resetn <= 1'b1;

        mark = errors;
        repeat (20) begin
            @(negedge clock);
            check_hex("frame_done", 32'(frame_done), 32'd0);
            check_hex("vga_valid", 32'(vga_valid), 32'd0);
            check_hex("collided", 32'(collided), 32'd0);
        end
        end_test("reset state", mark);

        mark = errors;
        frame_and_check(DIR_NONE, ghosts, 1'b0);
        end_test("raster scan", mark);

        mark = errors;
        frame_and_check(DIR_UP, ghosts, 1'b0);   // Border above
        check_hex("player_pos", 32'(u_maze_frame.player_pos), {23'd0, 5'd1, 4'd1});
        frame_and_check(DIR_RIGHT, ghosts, 1'b0);
        frame_and_check(DIR_RIGHT, ghosts, 1'b0);
        check_hex("player_pos", 32'(u_maze_frame.player_pos), {23'd0, 5'd3, 4'd1});
        check_hex("vga_color", 32'(pixels[7 * CANVAS_W + 17]), 32'(PLAYER_COLOR));
        check_hex("vga_color", 32'(pixels[7 * CANVAS_W + 7]), 32'(FLOOR_COLOR));
        end_test("moves and walls", mark);

        mark = errors;
        ghosts[0] = '{x: 5'd3, y: 4'd2};         // Waits below the player
        frame_and_check(DIR_DOWN, ghosts, 1'b0);
        check_hex("collided", 32'(collided), 32'd1);
        ghosts[0] = '{x: 5'd27, y: 4'd11};
        frame_and_check(DIR_NONE, ghosts, 1'b0);
        check_hex("collided", 32'(collided), 32'd0);
        end_test("collision", mark);

        mark = errors;
        frame_and_check(DIR_DOWN, ghosts, 1'b1);  // A restart would move twice
        end_test("start during frame", mark);

        mark = errors;
        repeat (10) begin
            rng = xorshift(rng);
            dir = dir_t'(3'(rng % 32'd5));
            for (int g = 0; g < NUM_GHOSTS; g++) begin
                rng = xorshift(rng);
                ghosts[g].x = tile_x_t'(rng % 32'(MAZE_COLS));
                ghosts[g].y = tile_y_t'((rng >> 8) % 32'(MAZE_ROWS));
            end
            if (rng[20]) begin
                ghosts[0] = next_tile(ref_pos, dir);   // Force a hit now and then
            end
            frame_and_check(dir, ghosts, 1'b0);
        end
        end_test("random frames", mark);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized for every frame plus reset
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation ran past the watchdog limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- maze_frame.f
maze_pkg.sv
canvas_write_if.sv
player_motion.sv
maze_painter.sv
player_painter.sv
frame_buffer.sv
canvas_scanout.sv
frame_sequencer.sv
maze_frame.sv
tb_maze_frame.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_maze_frame -f maze_frame.f || exit 1
out=$(./obj_dir/Vtb_maze_frame)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
